// ==== all.f ====
+incdir+sim
common/coreDefs.sv
logic/registerFile.sv
logic/alu.sv
core/instructionDecoder.sv
core/interruptController.sv
core/phaseController.sv
core/core.sv
sim/coreInterruptTests.sv

// ==== common/coreDefs.sv ====
`default_nettype none

package coreDefs;

	// Data path and register select widths
	localparam int dataWidth = 16;
	localparam int regSelWidth = 4;
	localparam int regCount = 2 ** regSelWidth;

	// Instruction word fields, each four bits wide
	localparam int fieldWidth = 4;
	localparam int groupLo = 12;
	localparam int opLo = 8;
	localparam int destLo = 4;
	localparam int srcLo = 0;

	// One instruction walks through these in order
	typedef enum logic [1:0] {
		phFetch,
		phDecode,
		phExecute,
		phCommit
	} phase_t;

	typedef enum logic [fieldWidth-1:0] {
		system = 4'd0,
		aluGroup = 4'd1,
		loadImm = 4'd2,
		store = 4'd3,
		jump = 4'd4
	} instrGroup_t;

	typedef enum logic [fieldWidth-1:0] {
		add = 4'd0,
		sub = 4'd1,
		andOp = 4'd2,
		orOp = 4'd3,
		xorOp = 4'd4
	} aluOp_t;

	typedef enum logic [fieldWidth-1:0] {
		nop = 4'd0,
		ei = 4'd1,
		di = 4'd2,
		reti = 4'd3,
		halt = 4'd4
	} sysOp_t;

	// Byte addresses
	localparam logic [dataWidth-1:0] resetVector = 16'h0000;
	localparam logic [dataWidth-1:0] int0Vector = 16'h0004;
	localparam logic [dataWidth-1:0] int1Vector = 16'h0008;
	localparam logic [dataWidth-1:0] pcStep = 16'd2;

endpackage

`default_nettype wire

// ==== core/core.sv ====
`timescale 1ns/1ps
`default_nettype none

module core (
	input  wire CLK,
	input  wire reset,
	input  wire int0,
	input  wire int1,
	input  wire [coreDefs::dataWidth-1:0] din,
	output wire [coreDefs::dataWidth-1:0] addr,
	output wire [coreDefs::dataWidth-1:0] dout,
	output wire rdn,
	output wire wrn,
	output wire fetch,
	output wire decode,
	output wire execute,
	output wire commit,
	output wire stopped
);

	import coreDefs::*;

	// Decoded instruction
	wire [dataWidth-1:0] instrWord;
	wire instrGroup_t group;
	wire aluOp_t aluOp;
	wire sysOp_t sysOp;
	wire [regSelWidth-1:0] selA;
	wire [regSelWidth-1:0] selB;
	wire illegal;

	// Data path
	wire [dataWidth-1:0] readA;
	wire [dataWidth-1:0] readB;
	wire [dataWidth-1:0] aluResult;
	wire writeEnable;
	wire [dataWidth-1:0] writeData;

	// Controller to interrupt logic and back
	wire endOfInstr;
	wire [dataWidth-1:0] nextPc;
	wire eiStrobe;
	wire diStrobe;
	wire retiStrobe;
	wire takeVector;
	wire [dataWidth-1:0] vectorAddr;
	wire returnNow;
	wire [dataWidth-1:0] returnAddr;

	phaseController controller (
		.CLK(CLK), .reset(reset), .din(din),
		.group(group), .sysOp(sysOp), .illegal(illegal),
		.readA(readA), .readB(readB), .aluResult(aluResult),
		.takeVector(takeVector), .vectorAddr(vectorAddr),
		.returnNow(returnNow), .returnAddr(returnAddr),
		.instrWord(instrWord), .addr(addr), .dout(dout), .rdn(rdn), .wrn(wrn),
		.writeEnable(writeEnable), .writeData(writeData),
		.endOfInstr(endOfInstr), .nextPc(nextPc),
		.eiStrobe(eiStrobe), .diStrobe(diStrobe), .retiStrobe(retiStrobe),
		.fetch(fetch), .decode(decode), .execute(execute), .commit(commit),
		.stopped(stopped)
	);

	instructionDecoder decoder (
		.instrWord(instrWord), .group(group), .aluOp(aluOp), .sysOp(sysOp),
		.selA(selA), .selB(selB), .illegal(illegal)
	);

	// Results always land in the destination field register
	registerFile regs (
		.CLK(CLK), .selA(selA), .selB(selB), .writeEnable(writeEnable),
		.writeSel(selA), .writeData(writeData), .readA(readA), .readB(readB)
	);

	alu aluUnit (
		.aluOp(aluOp), .a(readA), .b(readB), .result(aluResult)
	);

	interruptController interrupts (
		.CLK(CLK), .reset(reset), .int0(int0), .int1(int1),
		.endOfInstr(endOfInstr), .nextPc(nextPc),
		.eiStrobe(eiStrobe), .diStrobe(diStrobe), .retiStrobe(retiStrobe),
		.takeVector(takeVector), .vectorAddr(vectorAddr),
		.returnNow(returnNow), .returnAddr(returnAddr)
	);

endmodule

`default_nettype wire

// ==== core/instructionDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder (
	input  wire [coreDefs::dataWidth-1:0] instrWord,
	output coreDefs::instrGroup_t group,
	output coreDefs::aluOp_t aluOp,
	output coreDefs::sysOp_t sysOp,
	output logic [coreDefs::regSelWidth-1:0] selA,
	output logic [coreDefs::regSelWidth-1:0] selB,
	output logic illegal
);

	import coreDefs::*;

	logic [fieldWidth-1:0] groupCode;
	logic [fieldWidth-1:0] opCode;
	logic badGroup;
	logic badOp;

	// Raw fields
	assign groupCode = instrWord[groupLo +: fieldWidth];
	assign opCode = instrWord[opLo +: fieldWidth];

	// Destination field feeds port A, source field port B
	assign selA = instrWord[destLo +: regSelWidth];
	assign selB = instrWord[srcLo +: regSelWidth];

	assign group = instrGroup_t'(groupCode);
	assign aluOp = aluOp_t'(opCode);
	assign sysOp = sysOp_t'(opCode);

	// Group code past the last defined group
	assign badGroup = groupCode > jump;

	// Operation range depends on the group
	always_comb begin
		case (groupCode)
			system: begin
				badOp = opCode > halt;
			end
			aluGroup: begin
				badOp = opCode > xorOp;
			end
			default: begin
				// Load, store and jump ignore the operation field
				badOp = 1'b0;
			end
		endcase
	end

	assign illegal = badGroup || badOp;

endmodule

`default_nettype wire

// ==== core/interruptController.sv ====
`timescale 1ns/1ps
`default_nettype none

module interruptController (
	input  wire CLK,
	input  wire reset,
	input  wire int0,
	input  wire int1,
	input  wire endOfInstr,
	input  wire [coreDefs::dataWidth-1:0] nextPc,
	input  wire eiStrobe,
	input  wire diStrobe,
	input  wire retiStrobe,
	output logic takeVector,
	output logic [coreDefs::dataWidth-1:0] vectorAddr,
	output logic returnNow,
	output logic [coreDefs::dataWidth-1:0] returnAddr
);

	import coreDefs::*;

	logic enable;
	logic inService;
	logic takeInt0;
	logic takeInt1;

	// INT0 ignores the enable and wins over INT1
	assign takeInt0 = endOfInstr && int0 && !inService;
	assign takeInt1 = endOfInstr && !int0 && int1 && enable && !inService;

	assign takeVector = takeInt0 || takeInt1;
	assign vectorAddr = takeInt0 ? int0Vector : int1Vector;

	// A stray RETI outside a handler just falls through
	assign returnNow = retiStrobe && inService;

	always_ff @(posedge CLK) begin
		if (reset) begin
			enable <= 1'b0;
			inService <= 1'b0;
		end else begin
			if (eiStrobe)
				enable <= 1'b1;
			else if (diStrobe)
				enable <= 1'b0;

			if (takeVector)
				inService <= 1'b1;
			else if (returnNow)
				inService <= 1'b0;
		end
	end

	// Address to resume at after the handler
	always_ff @(posedge CLK) begin
		if (takeVector)
			returnAddr <= nextPc;
	end

	// No second vector until the handler has returned
	noNesting: assert property (@(posedge CLK) disable iff (reset)
		takeVector |=> !takeVector until returnNow);

	// A return only follows a taken vector
	returnAfterTake: assert property (@(posedge CLK) disable iff (reset)
		returnNow |=> !returnNow until takeVector);

endmodule

`default_nettype wire

// ==== core/phaseController.sv ====
`timescale 1ns/1ps
`default_nettype none

module phaseController (
	input  wire CLK,
	input  wire reset,
	input  wire [coreDefs::dataWidth-1:0] din,
	input  wire coreDefs::instrGroup_t group,
	input  wire coreDefs::sysOp_t sysOp,
	input  wire illegal,
	input  wire [coreDefs::dataWidth-1:0] readA,
	input  wire [coreDefs::dataWidth-1:0] readB,
	input  wire [coreDefs::dataWidth-1:0] aluResult,
	input  wire takeVector,
	input  wire [coreDefs::dataWidth-1:0] vectorAddr,
	input  wire returnNow,
	input  wire [coreDefs::dataWidth-1:0] returnAddr,
	output logic [coreDefs::dataWidth-1:0] instrWord,
	output logic [coreDefs::dataWidth-1:0] addr,
	output logic [coreDefs::dataWidth-1:0] dout,
	output logic rdn,
	output logic wrn,
	output logic writeEnable,
	output logic [coreDefs::dataWidth-1:0] writeData,
	output logic endOfInstr,
	output logic [coreDefs::dataWidth-1:0] nextPc,
	output logic eiStrobe,
	output logic diStrobe,
	output logic retiStrobe,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,
	output logic stopped
);

	import coreDefs::*;

	phase_t phase;
	logic running;
	logic immFetch;
	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] instrReg;
	logic [dataWidth-1:0] immReg;
	logic [dataWidth-1:0] resultReg;
	logic [dataWidth-1:0] immAddr;
	logic [dataWidth-1:0] seqPc;
	logic legalSys;
	logic haltNow;

	assign fetch = running && phase == phFetch;
	assign decode = running && phase == phDecode;
	assign execute = running && phase == phExecute;
	assign commit = running && phase == phCommit;

	// First fetch shows the bus word straight to the decoder
	assign instrWord = (fetch && !immFetch) ? din : instrReg;

	assign immAddr = pc + pcStep;
	assign seqPc = (group == loadImm) ? immAddr + pcStep : immAddr;
	assign nextPc = (group == jump) ? readB : seqPc;

	assign legalSys = group == system && !illegal;
	assign haltNow = commit && (illegal || (legalSys && sysOp == halt));
	assign endOfInstr = commit && !haltNow;
	assign eiStrobe = commit && legalSys && sysOp == ei;
	assign diStrobe = commit && legalSys && sysOp == di;
	assign retiStrobe = commit && legalSys && sysOp == reti;

	assign writeEnable = commit && !illegal && (group == aluGroup || group == loadImm);
	assign writeData = (group == loadImm) ? immReg : resultReg;

	assign rdn = !fetch;
	assign wrn = !(commit && !illegal && group == store);
	assign dout = readA;

	always_comb begin
		if (fetch)
			addr = immFetch ? immAddr : pc;
		else if (!wrn)
			addr = readB;
		else
			addr = pc;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= phFetch;
			running <= 1'b0;
			stopped <= 1'b0;
			immFetch <= 1'b0;
			pc <= resetVector;
		end else if (!running) begin
			running <= !stopped;
		end else begin
			case (phase)
				phFetch: begin
					if (immFetch) begin
						immFetch <= 1'b0;
						phase <= phDecode;
					end else if (group == loadImm) begin
						immFetch <= 1'b1;
					end else begin
						phase <= phDecode;
					end
				end
				phDecode: phase <= phExecute;
				phExecute: phase <= phCommit;
				phCommit: begin
					phase <= phFetch;
					// Vector beats return, return beats the program's own target
					if (haltNow) begin
						running <= 1'b0;
						stopped <= 1'b1;
					end else if (takeVector) begin
						pc <= vectorAddr;
					end else if (returnNow) begin
						pc <= returnAddr;
					end else begin
						pc <= nextPc;
					end
				end
				default: phase <= phFetch;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (fetch && !immFetch)
			instrReg <= din;
		if (fetch && immFetch)
			immReg <= din;
		if (execute)
			resultReg <= aluResult;
	end

	phaseOneHot: assert property (@(posedge CLK) disable iff (reset)
		$onehot0({fetch, decode, execute, commit}));

	strobesApart: assert property (@(posedge CLK) disable iff (reset) !(!rdn && !wrn));

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire coreDefs::aluOp_t aluOp,
	input  wire [coreDefs::dataWidth-1:0] a,
	input  wire [coreDefs::dataWidth-1:0] b,
	output logic [coreDefs::dataWidth-1:0] result
);

	import coreDefs::*;

	// Carries and borrows simply drop off the top
	always_comb begin
		case (aluOp)
			add: begin
				result = a + b;
			end
			sub: begin
				result = a - b;
			end
			andOp: begin
				result = a & b;
			end
			orOp: begin
				result = a | b;
			end
			xorOp: begin
				result = a ^ b;
			end
			default: begin
				// Undefined codes are trapped as illegal upstream
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input  wire CLK,
	input  wire [coreDefs::regSelWidth-1:0] selA,
	input  wire [coreDefs::regSelWidth-1:0] selB,
	input  wire writeEnable,
	input  wire [coreDefs::regSelWidth-1:0] writeSel,
	input  wire [coreDefs::dataWidth-1:0] writeData,
	output logic [coreDefs::dataWidth-1:0] readA,
	output logic [coreDefs::dataWidth-1:0] readB
);

	import coreDefs::*;

	logic [dataWidth-1:0] regs [regCount];

	// Single write port
	always_ff @(posedge CLK) begin
		if (writeEnable)
			regs[writeSel] <= writeData;
	end

	// Reads are combinational
	assign readA = regs[selA];
	assign readB = regs[selB];

endmodule

`default_nettype wire

// ==== sim/coreModel.svh ====
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// Model state comes back to its reset values
task automatic resetModel();
	mPc = resetVector;
	expectedFetch = resetVector;
	mEnable = 1'b0;
	mInService = 1'b0;
	mStopped = 1'b0;
	mStore = 1'b0;
endtask

// Runs one instruction on the modelled core and returns the next fetch address
function automatic logic [15:0] executeModel(input logic [15:0] word,
		input logic [15:0] imm, input logic irq0, input logic irq1);
	logic [3:0] grp;
	logic [3:0] op;
	logic [3:0] d;
	logic [3:0] s;
	logic [15:0] next;
	logic wasService;
	logic wasEnabled;
	grp = word[15:12];
	op = word[11:8];
	d = word[7:4];
	s = word[3:0];
	wasService = mInService;
	wasEnabled = mEnable;
	next = mPc + 16'd2;
	mStore = 1'b0;
	// Undefined codes stop the core like HALT
	if (grp > jump || (grp <= aluGroup && op > 4'd4) || (grp == system && op == halt)) begin
		mStopped = 1'b1;
		return mPc;
	end
	case (grp)
		system: begin
			if (op == ei)
				mEnable = 1'b1;
			if (op == di)
				mEnable = 1'b0;
			if (op == reti && wasService) begin
				next = mRetAddr;
				mInService = 1'b0;
			end
		end
		aluGroup: begin
			case (op)
				add: mRegs[d] = mRegs[d] + mRegs[s];
				sub: mRegs[d] = mRegs[d] - mRegs[s];
				andOp: mRegs[d] = mRegs[d] & mRegs[s];
				orOp: mRegs[d] = mRegs[d] | mRegs[s];
				default: mRegs[d] = mRegs[d] ^ mRegs[s];
			endcase
		end
		loadImm: begin
			mRegs[d] = imm;
			next = mPc + 16'd4;
		end
		store: begin
			mStore = 1'b1;
			mStoreAddr = mRegs[s];
			mStoreData = mRegs[d];
		end
		default: next = mRegs[s];
	endcase
	// INT0 is unmaskable and first, nothing nests
	if (!wasService && (irq0 || (irq1 && wasEnabled))) begin
		mRetAddr = next;
		next = irq0 ? int0Vector : int1Vector;
		mInService = 1'b1;
	end
	mPc = next;
	return next;
endfunction

`endif

// ==== sim/coreInterruptTests.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreInterruptTests;

	import coreDefs::*;

	logic CLK;
	logic reset;
	logic int0;
	logic int1;
	logic [15:0] din;
	wire [15:0] addr;
	wire [15:0] dout;
	wire rdn;
	wire wrn;
	wire fetch;
	wire decode;
	wire execute;
	wire commit;
	wire stopped;

	// Program words and the fetch addresses that raise each interrupt line
	logic [15:0] mem [256];
	logic raise0 [256];
	logic raise1 [256];
	integer loadPtr;

	// Modelled core
	logic [15:0] mRegs [16];
	logic [15:0] mPc;
	logic [15:0] mRetAddr;
	logic [15:0] mStoreAddr;
	logic [15:0] mStoreData;
	logic mEnable;
	logic mInService;
	logic mStopped;
	logic mStore;

	logic [15:0] expectedFetch;
	logic [15:0] fetchedWord;
	logic [15:0] fetchedImm;
	logic [3:0] expectedPhase;
	logic fetchedOnce;
	integer phaseCycles;
	integer compareErrors;
	integer seed;
	integer passCount;
	integer failCount;
	integer i;
	string testName;

	`include "coreModel.svh"

	core uut (
		.CLK(CLK), .reset(reset), .int0(int0), .int1(int1), .din(din),
		.addr(addr), .dout(dout), .rdn(rdn), .wrn(wrn), .fetch(fetch),
		.decode(decode), .execute(execute), .commit(commit), .stopped(stopped)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// Memory answers the address, interrupts drop when their vector is fetched
	initial begin
		int0 = 1'b0;
		int1 = 1'b0;
		din = 16'h0000;
		forever begin
			@(posedge CLK);
			#5;
			din = mem[addr[8:1]];
			if (stopped) begin
				int0 = 1'b0;
				int1 = 1'b0;
			end else if (fetch) begin
				if (addr == int0Vector)
					int0 = 1'b0;
				else if (raise0[addr[8:1]])
					int0 = 1'b1;
				if (addr == int1Vector)
					int1 = 1'b0;
				else if (raise1[addr[8:1]])
					int1 = 1'b1;
			end
		end
	end

	task automatic checkValue(input string what, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("Fail %s %s: expected %h, actual %h", testName, what, expected, actual);
			compareErrors = compareErrors + 1;
		end
	endtask

	// Pattern {fetch, decode, execute, commit} in the nth cycle of one instruction
	function automatic logic [3:0] phaseAt(input integer n, input logic twoFetches);
		integer k;
		k = twoFetches ? n - 1 : n;
		if (n == 1)
			return 4'b1000;
		else if (k >= 1 && k <= 4)
			return 4'b1000 >> (k - 1);
		else
			return 4'b0000;
	endfunction

	// Compare against the model at every fetch and commit
	initial begin
		compareErrors = 0;
		forever begin
			@(negedge CLK);
			if (reset) begin
				resetModel();
				fetchedOnce = 1'b0;
				phaseCycles = 0;
			end else begin
				if (fetch || decode || execute || commit)
					phaseCycles = phaseCycles + 1;
				if (fetch && !fetchedOnce) begin
					checkValue("fetch address", expectedFetch, addr);
					fetchedWord = din;
					fetchedOnce = 1'b1;
				end else if (fetch) begin
					// Second fetch of a loadImm
					checkValue("immediate address", expectedFetch + pcStep, addr);
					fetchedImm = din;
				end
				if (fetch || decode || execute || commit) begin
					expectedPhase = phaseAt(phaseCycles, fetchedWord[15:12] == loadImm);
					checkValue("phases", {12'd0, expectedPhase},
						{12'd0, fetch, decode, execute, commit});
					checkValue("read strobe", {15'd0, !expectedPhase[3]}, {15'd0, rdn});
					if (!expectedPhase[0])
						checkValue("write strobe", 16'd1, {15'd0, wrn});
				end
				if (commit) begin
					checkValue("phase cycles", (fetchedWord[15:12] == loadImm) ? 16'd5 : 16'd4,
						16'(phaseCycles));
					expectedFetch = executeModel(fetchedWord, fetchedImm, int0, int1);
					checkValue("write strobe", {15'd0, !mStore}, {15'd0, wrn});
					if (mStore) begin
						checkValue("store address", mStoreAddr, addr);
						checkValue("store data", mStoreData, dout);
					end
					fetchedOnce = 1'b0;
					phaseCycles = 0;
				end
			end
		end
	end

	function automatic logic [15:0] encode(input logic [3:0] grp, input logic [3:0] op,
			input logic [3:0] d, input logic [3:0] s);
		return {grp, op, d, s};
	endfunction

	task automatic place(input logic [15:0] word);
		mem[loadPtr] = word;
		loadPtr = loadPtr + 1;
	endtask

	task automatic moveTo(input logic [15:0] byteAddr);
		loadPtr = byteAddr >> 1;
	endtask

	task automatic loadImmWord(input logic [3:0] d, input logic [15:0] value);
		place(encode(loadImm, 4'd0, d, 4'd0));
		place(value);
	endtask

	// Illegal fill, then reset entry via r14 and vectors via r14 and r13
	task automatic startProgram();
		for (int a = 0; a < 256; a++) begin
			mem[a] = 16'hF000 | 16'(a);
			raise0[a] = 1'b0;
			raise1[a] = 1'b0;
		end
		loadPtr = 0;
		loadImmWord(4'd14, 16'h0020);
		place(encode(jump, 4'd0, 4'd0, 4'd14));
		moveTo(int1Vector);
		place(encode(jump, 4'd0, 4'd0, 4'd13));
		moveTo(16'h0020);
	endtask

	// INT0 handler overwrites r7 and stores it at r2
	task automatic placeInt0Handler();
		moveTo(16'h0080);
		loadImmWord(4'd7, 16'($random(seed)));
		place(encode(store, 4'd0, 4'd7, 4'd2));
		place(encode(system, reti, 4'd0, 4'd0));
	endtask

	task automatic runTest(input string name);
		integer cycles;
		integer misses;
		integer startErrors;
		testName = name;
		misses = 0;
		startErrors = compareErrors;
		@(posedge CLK);
		#5;
		reset = 1'b1;
		repeat (5) begin
			@(posedge CLK);
			#5;
			assert (rdn && wrn && !stopped && !(fetch || decode || execute || commit)) else begin
				$display("%s: strobes or phases active during reset", name);
				misses = misses + 1;
			end
		end
		reset = 1'b0;
		cycles = 0;
		while (!stopped && cycles < 3000) begin
			@(negedge CLK);
			cycles = cycles + 1;
		end
		if (!stopped) begin
			$display("%s: timed out waiting for the core to stop", name);
			misses = misses + 1;
		end else begin
			assert (mStopped) else begin
				$display("%s: core stopped before the model did", name);
				misses = misses + 1;
			end
			// Stays quiet until the next reset
			cycles = 0;
			while (cycles < 20) begin
				@(negedge CLK);
				assert (stopped && rdn && !fetch) else begin
					$display("%s: core fetched again after stopping", name);
					misses = misses + 1;
				end
				cycles = cycles + 1;
			end
		end
		misses = misses + compareErrors - startErrors;
		if (misses == 0) begin
			passCount = passCount + 1;
			$display("%s: ok", name);
		end else begin
			failCount = failCount + 1;
			$display("%s: %0d errors", name, misses);
		end
	endtask

	initial begin
		seed = 32'hdd3e136d;
		reset = 1'b1;
		passCount = 0;
		failCount = 0;

		startProgram();
		for (i = 0; i < 5; i++) begin
			loadImmWord(4'd1, 16'($random(seed)));
			loadImmWord(4'd2, 16'($random(seed)));
			place(encode(aluGroup, i[3:0], 4'd1, 4'd2));
			loadImmWord(4'd3, 16'($random(seed)));
			place(encode(store, 4'd0, 4'd1, 4'd3));
		end
		place(encode(system, halt, 4'd0, 4'd0));
		runTest("reset, ALU and store");

		startProgram();
		loadImmWord(4'd5, 16'h0040);
		place(encode(jump, 4'd0, 4'd0, 4'd5));
		moveTo(16'h0040);
		place(encode(system, halt, 4'd0, 4'd0));
		runTest("jump through register");

		startProgram();
		loadImmWord(4'd14, 16'h0080);
		loadImmWord(4'd1, 16'($random(seed)));
		loadImmWord(4'd2, 16'($random(seed)));
		raise0[loadPtr] = 1'b1;
		place(encode(system, nop, 4'd0, 4'd0));
		place(encode(system, nop, 4'd0, 4'd0));
		place(encode(store, 4'd0, 4'd1, 4'd2));
		place(encode(system, halt, 4'd0, 4'd0));
		placeInt0Handler();
		runTest("INT0 with enable clear");

		// INT1 waits for EI, is masked after DI, and holds INT0 off while served
		startProgram();
		loadImmWord(4'd14, 16'h0080);
		loadImmWord(4'd13, 16'h00a0);
		loadImmWord(4'd1, 16'($random(seed)));
		loadImmWord(4'd2, 16'($random(seed)));
		raise1[loadPtr] = 1'b1;
		place(encode(system, nop, 4'd0, 4'd0));
		place(encode(system, nop, 4'd0, 4'd0));
		place(encode(system, ei, 4'd0, 4'd0));
		place(encode(system, nop, 4'd0, 4'd0));
		place(encode(system, di, 4'd0, 4'd0));
		raise1[loadPtr] = 1'b1;
		place(encode(system, nop, 4'd0, 4'd0));
		place(encode(system, nop, 4'd0, 4'd0));
		place(encode(store, 4'd0, 4'd1, 4'd2));
		place(encode(system, halt, 4'd0, 4'd0));
		placeInt0Handler();
		moveTo(16'h00a0);
		raise0[loadPtr] = 1'b1;
		place(encode(system, nop, 4'd0, 4'd0));
		place(encode(system, nop, 4'd0, 4'd0));
		place(encode(system, reti, 4'd0, 4'd0));
		runTest("INT1 mask and INT0 held off");

		startProgram();
		loadImmWord(4'd1, 16'($random(seed)));
		// Group 7 is undefined
		place(16'h7123);
		runTest("illegal word");

		$display("Tests passed: %0d, with errors: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
